/* hw/mci_pkg.sv */
////////////////////////////////
// Bus transaction types
////////////////////////////////

// Port view shared by SoC, MCU, CSR and SRAM.
// The handshake is valid/hold:
//   requester raises dv with req
//   accepted when dv high and hold low
//   req kept stable while hold is high
//   rdata arrives one cycle after an accepted read
package mci_pkg;

    // Word and address widths
    localparam int unsigned DATA_W = 32;
    localparam int unsigned ADDR_W = 32;

    ////////////////////////////////
    // Request
    ////////////////////////////////

    // Byte address, word write data, write flag
    // 65 bits in total
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              write;
    } mci_req_t;

    ////////////////////////////////
    // Response
    ////////////////////////////////

    // rdata is valid only in the cycle after an accepted read
    // error belongs to the accepting cycle
    // 33 bits in total
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              error;
    } mci_rsp_t;

endpackage

/* hw/mci_map_pkg.sv */
////////////////////////////////
// Memory map
////////////////////////////////

// Address regions seen from the SoC port and the CSR layout
package mci_map_pkg;

    import mci_pkg::*;

    // Region sizes are given in KB
    localparam int unsigned KB = 1024;

    // CSR region at the bottom of the map
    localparam logic [ADDR_W-1:0] CSR_START_ADDR = 32'h0000_0000;
    localparam int unsigned       CSR_SIZE_KB    = 4;

    // MCU SRAM window, size set per instance
    localparam logic [ADDR_W-1:0] MCU_SRAM_START_ADDR = 32'h0002_0000;

    ////////////////////////////////
    // CSR register indices
    ////////////////////////////////

    // Scratch words live at indices 0 to 7
    localparam int unsigned CSR_NUM_SCRATCH = 8;

    // Read-only identification word right after the scratch words
    localparam int unsigned CSR_ID_IDX = 8;

    // Value returned by the ID register
    // ASCII "MCI" plus a revision byte
    localparam logic [DATA_W-1:0] CSR_ID_VALUE = 32'h4D43_4901;

endpackage

/* hw/mci_axi_sub_decode.sv */
`timescale 1ns/100ps

module mci_axi_sub_decode
    import mci_pkg::*;
    import mci_map_pkg::*;
#(
    parameter int unsigned MCU_SRAM_SIZE_KB = 4
) (
    input  logic     clk,
    input  logic     rst_n,

    // SoC side
    input  logic     soc_dv,
    input  mci_req_t soc_req,
    output logic     soc_hold,
    output mci_rsp_t soc_rsp,

    // CSR block
    output logic     csr_dv,
    output mci_req_t csr_req,
    input  mci_rsp_t csr_rsp,

    // SRAM arbiter, SoC leg
    output logic     sram_dv,
    output mci_req_t sram_req,
    input  logic     sram_hold,
    input  mci_rsp_t sram_rsp
);

    // Inclusive end addresses of each region
    localparam logic [ADDR_W-1:0] CSR_END_ADDR =
        ADDR_W'(CSR_START_ADDR + CSR_SIZE_KB * KB - 1);
    localparam logic [ADDR_W-1:0] MCU_SRAM_END_ADDR =
        ADDR_W'(MCU_SRAM_START_ADDR + MCU_SRAM_SIZE_KB * KB - 1);

    logic csr_hit;
    logic sram_hit;
    logic soc_miss;

    // Owner of the read data due next cycle
    logic rd_csr_q;
    logic rd_sram_q;

    ////////////////////////////////
    // Address decode
    ////////////////////////////////

    always_comb csr_hit  = soc_req.addr inside {[CSR_START_ADDR:CSR_END_ADDR]};
    always_comb sram_hit = soc_req.addr inside {[MCU_SRAM_START_ADDR:MCU_SRAM_END_ADDR]};

    // Neither region matched
    always_comb soc_miss = soc_dv & ~csr_hit & ~sram_hit;

    ////////////////////////////////
    // Request toward targets
    ////////////////////////////////

    // dv only to the matching target
    always_comb csr_dv  = soc_dv & csr_hit;
    always_comb sram_dv = soc_dv & sram_hit;

    // Address passed untouched, targets strip their own base
    always_comb csr_req  = soc_req;
    always_comb sram_req = soc_req;

    ////////////////////////////////
    // Read data owner
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_csr_q  <= 1'b0;
            rd_sram_q <= 1'b0;
        end else begin
            // CSR never holds
            rd_csr_q  <= csr_dv & ~soc_req.write;
            // SRAM read counts only once the arbiter lets it through
            rd_sram_q <= sram_dv & ~sram_hold & ~soc_req.write;
        end
    end

    ////////////////////////////////
    // Response back to SoC
    ////////////////////////////////

    // Hold only comes from SRAM contention
    always_comb soc_hold = sram_dv & sram_hold;

    always_comb begin
        soc_rsp.rdata = rd_csr_q  ? csr_rsp.rdata  :
                        rd_sram_q ? sram_rsp.rdata : '0;
        // Target error or a miss, in the accepting cycle
        soc_rsp.error = (csr_dv & csr_rsp.error) |
                        (sram_dv & ~sram_hold & sram_rsp.error) |
                        soc_miss;
    end

endmodule

/* hw/mci_csr.sv */
`timescale 1ns/100ps

module mci_csr
    import mci_pkg::*;
    import mci_map_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dv,
    input  mci_req_t req,
    output mci_rsp_t rsp
);

    // Word index covers the whole CSR region
    localparam int unsigned IDX_W     = $clog2(CSR_SIZE_KB * KB / 4);
    localparam int unsigned SCR_IDX_W = $clog2(CSR_NUM_SCRATCH);

    logic [ADDR_W-1:0] offset;
    logic [IDX_W-1:0]  idx;
    logic              is_scratch;
    logic              is_id;
    logic              access_err;
    logic [DATA_W-1:0] rd_word;
    logic [DATA_W-1:0] rdata_q;

    // Scratch register file
    logic [DATA_W-1:0] scratch_q [CSR_NUM_SCRATCH];

    ////////////////////////////////
    // Index decode
    ////////////////////////////////

    always_comb offset     = req.addr - CSR_START_ADDR;
    always_comb idx        = offset[IDX_W+1:2];
    always_comb is_scratch = idx < CSR_NUM_SCRATCH;
    always_comb is_id      = idx == CSR_ID_IDX;

    // ID write or anything past the ID word
    always_comb access_err = dv & ((is_id & req.write) | (~is_scratch & ~is_id));

    // Read mux
    always_comb begin
        rd_word = '0;
        if (is_scratch) begin
            rd_word = scratch_q[idx[SCR_IDX_W-1:0]];
        end else if (is_id) begin
            rd_word = CSR_ID_VALUE;
        end
    end

    ////////////////////////////////
    // Register update
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < CSR_NUM_SCRATCH; i++) begin
                scratch_q[i] <= '0;
            end
            rdata_q <= '0;
        end else begin
            // Only scratch words take writes
            if (dv && req.write && is_scratch) begin
                scratch_q[idx[SCR_IDX_W-1:0]] <= req.wdata;
            end
            // Zero unless a read was accepted
            rdata_q <= (dv && !req.write) ? rd_word : '0;
        end
    end

    always_comb begin
        rsp.rdata = rdata_q;
        rsp.error = access_err;
    end

endmodule

/* hw/mci_sram_arb.sv */
`timescale 1ns/100ps

module mci_sram_arb
    import mci_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // SoC requester, already decoded
    input  logic     soc_dv,
    input  mci_req_t soc_req,
    output logic     soc_hold,
    output mci_rsp_t soc_rsp,

    // MCU requester
    input  logic     mcu_dv,
    input  mci_req_t mcu_req,
    output logic     mcu_hold,
    output mci_rsp_t mcu_rsp,

    // Single SRAM port
    output logic     sram_dv,
    output mci_req_t sram_req,
    input  mci_rsp_t sram_rsp
);

    logic contend;
    logic gnt_soc;
    logic gnt_mcu;

    // Set when SoC won the last contended cycle
    logic last_soc_q;

    // Read data owner for next cycle
    logic rd_soc_q;
    logic rd_mcu_q;

    ////////////////////////////////
    // Grant
    ////////////////////////////////

    always_comb contend = soc_dv & mcu_dv;

    // Lone requester wins at once
    // under contention the side that lost last time wins
    always_comb gnt_soc = soc_dv & (~mcu_dv | ~last_soc_q);
    always_comb gnt_mcu = mcu_dv & ~gnt_soc;

    always_comb soc_hold = soc_dv & ~gnt_soc;
    always_comb mcu_hold = mcu_dv & ~gnt_mcu;

    // Winner goes to the SRAM
    always_comb sram_dv  = gnt_soc | gnt_mcu;
    always_comb sram_req = gnt_soc ? soc_req : mcu_req;

    ////////////////////////////////
    // State
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // MCU counts as last winner so SoC gets the first tie
            last_soc_q <= 1'b0;
            rd_soc_q   <= 1'b0;
            rd_mcu_q   <= 1'b0;
        end else begin
            // Flips on every contended grant
            if (contend) begin
                last_soc_q <= gnt_soc;
            end
            rd_soc_q <= gnt_soc & ~soc_req.write;
            rd_mcu_q <= gnt_mcu & ~mcu_req.write;
        end
    end

    ////////////////////////////////
    // Responses
    ////////////////////////////////

    always_comb begin
        soc_rsp.rdata = rd_soc_q ? sram_rsp.rdata : '0;
        soc_rsp.error = gnt_soc & sram_rsp.error;
        mcu_rsp.rdata = rd_mcu_q ? sram_rsp.rdata : '0;
        mcu_rsp.error = gnt_mcu & sram_rsp.error;
    end

endmodule

/* hw/mci_sram.sv */
`timescale 1ns/100ps

module mci_sram
    import mci_pkg::*;
    import mci_map_pkg::*;
#(
    parameter int unsigned MCU_SRAM_SIZE_KB = 4
) (
    input  logic     clk,
    input  logic     dv,
    input  mci_req_t req,
    output mci_rsp_t rsp
);

    // Word depth and index width from the size in KB
    localparam int unsigned DEPTH = MCU_SRAM_SIZE_KB * KB / (DATA_W / 8);
    localparam int unsigned IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] rdata_q;

    // Storage array
    logic [DATA_W-1:0] mem [DEPTH];

    ////////////////////////////////
    // Word index
    ////////////////////////////////

    // Bits above the depth are dropped
    // so SoC window and MCU offsets land on the same word
    always_comb idx = req.addr[IDX_W+1:2];

    // Write at the edge, read registered
    always_ff @(posedge clk) begin
        if (dv && req.write) begin
            mem[idx] <= req.wdata;
        end
        if (dv && !req.write) begin
            rdata_q <= mem[idx];
        end
    end

    always_comb begin
        rsp.rdata = rdata_q;
        // No error source inside the array
        rsp.error = 1'b0;
    end

endmodule

/* hw/mci_top.sv */
`timescale 1ns/100ps

module mci_top
    import mci_pkg::*;
#(
    parameter int unsigned MCU_SRAM_SIZE_KB = 4
) (
    input  logic     clk,
    input  logic     rst_n,

    // SoC port, full map
    input  logic     soc_dv,
    input  mci_req_t soc_req,
    output logic     soc_hold,
    output mci_rsp_t soc_rsp,

    // MCU port, SRAM offsets only
    input  logic     mcu_dv,
    input  mci_req_t mcu_req,
    output logic     mcu_hold,
    output mci_rsp_t mcu_rsp
);

    // Decoder to CSR
    logic     csr_dv;
    mci_req_t csr_req;
    mci_rsp_t csr_rsp;

    // Decoder to arbiter
    logic     arb_soc_dv;
    mci_req_t arb_soc_req;
    logic     arb_soc_hold;
    mci_rsp_t arb_soc_rsp;

    // Arbiter to SRAM
    logic     sram_dv;
    mci_req_t sram_req;
    mci_rsp_t sram_rsp;

    ////////////////////////////////
    // SoC address decode
    ////////////////////////////////

    mci_axi_sub_decode #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .soc_dv    (soc_dv),
        .soc_req   (soc_req),
        .soc_hold  (soc_hold),
        .soc_rsp   (soc_rsp),
        .csr_dv    (csr_dv),
        .csr_req   (csr_req),
        .csr_rsp   (csr_rsp),
        .sram_dv   (arb_soc_dv),
        .sram_req  (arb_soc_req),
        .sram_hold (arb_soc_hold),
        .sram_rsp  (arb_soc_rsp)
    );

    // Register block
    mci_csr i_csr (
        .clk   (clk),
        .rst_n (rst_n),
        .dv    (csr_dv),
        .req   (csr_req),
        .rsp   (csr_rsp)
    );

    ////////////////////////////////
    // Shared SRAM
    ////////////////////////////////

    mci_sram_arb i_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .soc_dv   (arb_soc_dv),
        .soc_req  (arb_soc_req),
        .soc_hold (arb_soc_hold),
        .soc_rsp  (arb_soc_rsp),
        .mcu_dv   (mcu_dv),
        .mcu_req  (mcu_req),
        .mcu_hold (mcu_hold),
        .mcu_rsp  (mcu_rsp),
        .sram_dv  (sram_dv),
        .sram_req (sram_req),
        .sram_rsp (sram_rsp)
    );

    mci_sram #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) i_sram (
        .clk (clk),
        .dv  (sram_dv),
        .req (sram_req),
        .rsp (sram_rsp)
    );

endmodule

/* test/mci_properties.sv */
`timescale 1ns/100ps

////////////////////////////////
// Arbiter checks
////////////////////////////////

module mci_arb_properties (
    input logic clk,
    input logic rst_n,
    input logic soc_dv,
    input logic mcu_dv,
    input logic soc_hold,
    input logic mcu_hold,
    input logic sram_dv
);

    // Set once any assertion below fails
    logic failed = 1'b0;

    // One winner per cycle
    a_hold_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(soc_hold && mcu_hold)
    ) else begin
        failed = 1'b1;
        $error("arbiter holds both requesters");
    end

    // Hold only under contention
    a_hold_needs_both: assert property (
        @(posedge clk) disable iff (!rst_n)
        (soc_hold || mcu_hold) |-> (soc_dv && mcu_dv)
    ) else begin
        failed = 1'b1;
        $error("arbiter holds without contention");
    end

    // SRAM busy whenever anyone asks
    a_sram_dv_or: assert property (
        @(posedge clk) disable iff (!rst_n)
        sram_dv == (soc_dv || mcu_dv)
    ) else begin
        failed = 1'b1;
        $error("sram_dv differs from the OR of both requests");
    end

    // Loser wins the next tie
    a_no_double_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        soc_hold |=> !soc_hold
    ) else begin
        failed = 1'b1;
        $error("soc held for two cycles in a row");
    end

endmodule

bind mci_sram_arb mci_arb_properties i_arb_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .soc_dv   (soc_dv),
    .mcu_dv   (mcu_dv),
    .soc_hold (soc_hold),
    .mcu_hold (mcu_hold),
    .sram_dv  (sram_dv)
);

/* test/mci_tb.sv */
`timescale 1ns/100ps

module mci_tb
    import mci_pkg::*;
    import mci_map_pkg::*;
();

    // SRAM size under test and derived depth
    localparam int unsigned SRAM_KB    = 4;
    localparam int unsigned SRAM_WORDS = SRAM_KB * KB / 4;

    // Case file layout, six words per access
    localparam int unsigned FIELDS    = 6;
    localparam int unsigned MAX_CASES = 64;

    // Random phase, SoC and MCU each own half of a small window
    localparam int unsigned NUM_RANDOM = 200;
    localparam int unsigned RAND_BASE  = 256;
    localparam int unsigned RAND_HALF  = 32;

    logic     clk;
    logic     rst_n;
    logic     soc_dv;
    mci_req_t soc_req;
    logic     soc_hold;
    mci_rsp_t soc_rsp;
    logic     mcu_dv;
    mci_req_t mcu_req;
    logic     mcu_hold;
    mci_rsp_t mcu_rsp;

    // Reference contents
    logic [DATA_W-1:0] sram_model [SRAM_WORDS];
    bit                sram_known [SRAM_WORDS];
    logic [DATA_W-1:0] csr_model  [CSR_NUM_SCRATCH];

    logic [31:0] case_mem [MAX_CASES*FIELDS];
    int          num_cases;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    logic [31:0] rng_state;
    bit          contend_seen;

    mci_top #(
        .MCU_SRAM_SIZE_KB (SRAM_KB)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .soc_dv   (soc_dv),
        .soc_req  (soc_req),
        .soc_hold (soc_hold),
        .soc_rsp  (soc_rsp),
        .mcu_dv   (mcu_dv),
        .mcu_req  (mcu_req),
        .mcu_hold (mcu_hold),
        .mcu_rsp  (mcu_rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////
    // Helpers
    ////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // SoC window of the SRAM
    function automatic bit in_sram_window(input logic [31:0] addr);
        return (addr >= MCU_SRAM_START_ADDR) && (addr < MCU_SRAM_START_ADDR + SRAM_KB * KB);
    endfunction

    // Address bits above the depth are ignored
    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % SRAM_WORDS);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR t=%0t %s got=%h expected=%h", $time, name, got, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic drive(input bit port, input logic dv, input mci_req_t req);
        if (port) begin
            mcu_dv  = dv;
            mcu_req = req;
        end else begin
            soc_dv  = dv;
            soc_req = req;
        end
    endtask

    // One access on a port, kept stable through hold
    task automatic access(input bit port, input bit write, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
        string       pname;
        mci_req_t    req;
        logic        hold;
        logic [31:0] rsp_data;
        bit          held;
        pname     = port ? "mcu" : "soc";
        req.addr  = addr;
        req.wdata = wdata;
        req.write = write;
        held      = 1'b0;
        rdata     = '0;
        @(posedge clk);
        #1;
        drive(port, 1'b1, req);
        do begin
            @(negedge clk);
            hold     = port ? mcu_hold : soc_hold;
            rsp_data = port ? mcu_rsp.rdata : soc_rsp.rdata;
            err      = port ? mcu_rsp.error : soc_rsp.error;
            // No read data outside its own cycle
            check({pname, "_rsp.rdata"}, rsp_data, '0);
            // At most one held cycle per access
            if (held) begin
                check({pname, "_hold"}, hold, 1'b0);
            end
            if (hold) begin
                held = 1'b1;
                @(posedge clk);
                #1;
            end
        end while (hold);
        @(posedge clk);
        #1;
        drive(port, 1'b0, '0);
        if (!write) begin
            @(negedge clk);
            rdata = port ? mcu_rsp.rdata : soc_rsp.rdata;
        end
    endtask

    // Reference update for an accepted write without error
    task automatic model_write(input bit port, input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] csr_idx;
        csr_idx = (addr - CSR_START_ADDR) >> 2;
        if (port || in_sram_window(addr)) begin
            sram_model[word_index(addr)] = wdata;
            sram_known[word_index(addr)] = 1'b1;
        end else if (csr_idx < CSR_NUM_SCRATCH) begin
            csr_model[csr_idx] = wdata;
        end
    endtask

    ////////////////////////////////
    // Monitors
    ////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            // Idle port never sees hold
            if (!soc_dv) check("soc_hold", soc_hold, 1'b0);
            if (!mcu_dv) check("mcu_hold", mcu_hold, 1'b0);
            // First tie after reset belongs to SoC
            if (!contend_seen && soc_dv && mcu_dv && in_sram_window(soc_req.addr)) begin
                contend_seen = 1'b1;
                check("soc_hold", soc_hold, 1'b0);
                check("mcu_hold", mcu_hold, 1'b1);
            end
            // Bound arbiter assertions
            if (i_dut.i_arb.i_arb_properties.failed) begin
                $display("An arbiter assertion failed");
                $display("TB FAILED");
                $fatal(1, "assertion failure");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////
    // Sequence
    ////////////////////////////////

    initial begin
        bit          port;
        bit          wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rd;
        logic        exp_err;
        logic [31:0] rdata;
        logic        err;
        string       pname;
        int          s_idx;
        int          m_idx;
        bit          s_wr;
        bit          m_wr;
        logic [31:0] s_wdata;
        logic [31:0] m_wdata;
        logic [31:0] s_rd;
        logic [31:0] m_rd;
        logic        s_err;
        logic        m_err;

        soc_dv       = 1'b0;
        soc_req      = '0;
        mcu_dv       = 1'b0;
        mcu_req      = '0;
        rst_n        = 1'b0;
        rng_state    = 32'd2;
        contend_seen = 1'b0;
        for (int i = 0; i < SRAM_WORDS; i++) sram_known[i] = 1'b0;
        for (int i = 0; i < CSR_NUM_SCRATCH; i++) csr_model[i] = '0;

        $readmemh("test/mci_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && !$isunknown(case_mem[num_cases*FIELDS])) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No cases could be read from test/mci_cases.txt");
            $display("TB FAILED");
            $fatal(1, "empty case file");
        end
        // Directed, CSR readback and random accesses, plus reset
        cycle_limit = (num_cases + CSR_NUM_SCRATCH + NUM_RANDOM) * 40 + 16;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Directed accesses from the case file
        for (int n = 0; n < num_cases; n++) begin
            port    = case_mem[n*FIELDS][0];
            wr      = case_mem[n*FIELDS+1][0];
            addr    = case_mem[n*FIELDS+2];
            wdata   = case_mem[n*FIELDS+3];
            exp_rd  = case_mem[n*FIELDS+4];
            exp_err = case_mem[n*FIELDS+5][0];
            pname   = port ? "mcu" : "soc";
            access(port, wr, addr, wdata, rdata, err);
            check({pname, "_rsp.error"}, err, exp_err);
            if (!wr) begin
                check({pname, "_rsp.rdata"}, rdata, exp_rd);
            end else if (!err) begin
                model_write(port, addr, wdata);
            end
        end

        // Scratch words against the reference
        for (int n = 0; n < CSR_NUM_SCRATCH; n++) begin
            access(1'b0, 1'b0, CSR_START_ADDR + n * 4, '0, rdata, err);
            check("soc_rsp.error", err, 1'b0);
            check("soc_rsp.rdata", rdata, csr_model[n]);
        end

        ////////////////////////////////
        // Contention
        ////////////////////////////////

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng_state = lcg_next(rng_state);
            s_idx     = RAND_BASE + rng_state[23:16] % RAND_HALF;
            s_wr      = rng_state[28] | !sram_known[s_idx];
            rng_state = lcg_next(rng_state);
            s_wdata   = rng_state;
            rng_state = lcg_next(rng_state);
            m_idx     = RAND_BASE + RAND_HALF + rng_state[23:16] % RAND_HALF;
            m_wr      = rng_state[28] | !sram_known[m_idx];
            rng_state = lcg_next(rng_state);
            m_wdata   = rng_state;
            // Both ports start on the same edge
            fork
                access(1'b0, s_wr, MCU_SRAM_START_ADDR + s_idx * 4, s_wdata, s_rd, s_err);
                access(1'b1, m_wr, m_idx * 4, m_wdata, m_rd, m_err);
            join
            check("soc_rsp.error", s_err, 1'b0);
            check("mcu_rsp.error", m_err, 1'b0);
            if (s_wr) model_write(1'b0, MCU_SRAM_START_ADDR + s_idx * 4, s_wdata);
            else check("soc_rsp.rdata", s_rd, sram_model[s_idx]);
            if (m_wr) model_write(1'b1, m_idx * 4, m_wdata);
            else check("mcu_rsp.rdata", m_rd, sram_model[m_idx]);
        end

        if (!contend_seen) begin
            $display("No contended SRAM access was observed");
            $display("TB FAILED");
            $fatal(1, "missing contention");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* test/mci_cases.txt */
// port(0 soc, 1 mcu) write addr wdata exp_rdata exp_error
// exp_rdata is checked on reads only
0 1 00020010 a5a55a5a 00000000 0
0 0 00020010 00000000 a5a55a5a 0
0 1 00020ffc 12345678 00000000 0
0 0 00020ffc 00000000 12345678 0
0 1 00020000 0f0f0f0f 00000000 0
0 0 00000000 00000000 00000000 0
0 0 0000001c 00000000 00000000 0
0 1 00000004 cafef00d 00000000 0
0 0 00000004 00000000 cafef00d 0
0 1 0000001c 0badbeef 00000000 0
0 0 0000001c 00000000 0badbeef 0
0 0 00000020 00000000 4d434901 0
0 1 00000020 ffffffff 00000000 1
0 0 00000020 00000000 4d434901 0
0 1 00000024 11111111 00000000 1
0 0 00000024 00000000 00000000 1
0 1 00000ffc 22222222 00000000 1
0 0 0000001c 00000000 0badbeef 0
0 1 00010000 deaddead 00000000 1
0 0 00010000 00000000 00000000 1
0 1 00021000 deaddead 00000000 1
0 0 00020000 00000000 0f0f0f0f 0
0 0 00020010 00000000 a5a55a5a 0
1 1 00000040 13572468 00000000 0
0 0 00020040 00000000 13572468 0
0 1 00020044 24681357 00000000 0
1 0 00000044 00000000 24681357 0
1 0 00001044 00000000 24681357 0

/* build.f */
hw/mci_pkg.sv
hw/mci_map_pkg.sv
hw/mci_axi_sub_decode.sv
hw/mci_csr.sv
hw/mci_sram_arb.sv
hw/mci_sram.sv
hw/mci_top.sv
test/mci_properties.sv
test/mci_tb.sv

/* Bender.yml */
# Manufacturer control interface memory subsystem
package:
  name: mci

sources:
  # Packages first, then the design
  - hw/mci_pkg.sv
  - hw/mci_map_pkg.sv
  - hw/mci_axi_sub_decode.sv
  - hw/mci_csr.sv
  - hw/mci_sram_arb.sv
  - hw/mci_sram.sv
  - hw/mci_top.sv

  # Simulation only
  - target: test
    files:
      - test/mci_properties.sv
      - test/mci_tb.sv
